// File: logic/scratch_pkg.sv
package scratch_pkg;

  // Word size
  localparam int WORD_W = 32;

  // Host view of the array
  localparam int ROWS  = 12;
  localparam int COLS  = 8;
  localparam int ROW_W = 4;
  localparam int COL_W = 3;

  // Flat address is row * COLS + col
  localparam int FLAT_W = 7;

  // Bank split, low bits of the flat address pick the bank
  localparam int BANKS      = 4;
  localparam int BANK_SEL_W = 2;
  localparam int BANK_DEPTH = (ROWS * COLS) / BANKS;
  localparam int OFF_W      = FLAT_W - BANK_SEL_W;

  // Host request, held stable while req is high
  typedef struct packed {
    logic             write;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [WORD_W-1:0] wdata;
  } mem_req_t;

  // Single-cycle command to one bank
  typedef struct packed {
    logic              read_en;
    logic              write_en;
    logic [OFF_W-1:0]  offset;
    logic [WORD_W-1:0] wdata;
  } bank_cmd_t;

  // Response returned with ack
  typedef struct packed {
    logic [WORD_W-1:0] rdata;
    logic              oob;
  } mem_rsp_t;

endpackage

// File: logic/word_bank.sv
`timescale 1ns/1ps

module word_bank (
  input  logic                           clk,
  input  logic                           reset,
  input  scratch_pkg::bank_cmd_t         cmd,
  output logic [scratch_pkg::WORD_W-1:0] read_data,
  output logic                           read_done,
  output logic                           write_done
);

  // Bank storage, contents survive reset
  logic [scratch_pkg::WORD_W-1:0] mem [scratch_pkg::BANK_DEPTH];

  logic [scratch_pkg::WORD_W-1:0] read_q;

  assign read_data = read_q;

  // Registered read port
  always_ff @(posedge clk) begin
    if (cmd.read_en) begin
      read_q <= mem[cmd.offset];
    end else if (cmd.write_en) begin
      // A write leaves the read output undefined
      read_q <= 'x;
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (cmd.write_en) begin
      mem[cmd.offset] <= cmd.wdata;
    end
  end

  // Read done follows a read command by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      read_done <= 1'b0;
    end else if (cmd.read_en) begin
      read_done <= 1'b1;
    end else begin
      read_done <= 1'b0;
    end
  end

  // Same for writes
  always_ff @(posedge clk) begin
    if (reset) begin
      write_done <= 1'b0;
    end else if (cmd.write_en) begin
      write_done <= 1'b1;
    end else begin
      write_done <= 1'b0;
    end
  end

endmodule

// File: logic/request_dispatch.sv
`timescale 1ns/1ps

module request_dispatch (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          req,
  input  scratch_pkg::mem_req_t                         mem_req,
  input  logic                                          ack,
  output scratch_pkg::bank_cmd_t [scratch_pkg::BANKS-1:0] bank_cmd,
  output logic                                          oob_hit
);

  // IDLE waits for a request, BUSY waits for req to drop,
  // RELEASE waits for ack to drop
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    RELEASE
  } disp_state_t;

  disp_state_t state;

  logic                                  issue;
  logic                                  in_range;
  logic [scratch_pkg::FLAT_W-1:0]        flat_addr;
  logic [scratch_pkg::BANK_SEL_W-1:0]    bank_sel;
  logic [scratch_pkg::OFF_W-1:0]         offset;

  logic [scratch_pkg::BANKS-1:0]         rd_en_q;
  logic [scratch_pkg::BANKS-1:0]         wr_en_q;
  logic [scratch_pkg::OFF_W-1:0]         offset_q;
  logic [scratch_pkg::WORD_W-1:0]        wdata_q;

  // One command per request, only from idle
  assign issue = (state == IDLE) && req && !ack;

  // Column is always below COLS with 3 bits, checked anyway
  assign in_range = (32'(mem_req.row) < scratch_pkg::ROWS) &&
                    (32'(mem_req.col) < scratch_pkg::COLS);

  assign flat_addr = scratch_pkg::FLAT_W'(mem_req.row) *
                     scratch_pkg::FLAT_W'(scratch_pkg::COLS) +
                     scratch_pkg::FLAT_W'(mem_req.col);

  assign bank_sel = flat_addr[scratch_pkg::BANK_SEL_W-1:0];
  assign offset   = flat_addr[scratch_pkg::FLAT_W-1:scratch_pkg::BANK_SEL_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (issue) begin
            state <= BUSY;
          end
        end
        BUSY: begin
          if (!req) begin
            state <= RELEASE;
          end
        end
        RELEASE: begin
          if (!ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Enables and oob pulse last exactly one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_en_q <= '0;
      wr_en_q <= '0;
      oob_hit <= 1'b0;
    end else begin
      rd_en_q <= '0;
      wr_en_q <= '0;
      oob_hit <= 1'b0;
      if (issue) begin
        if (!in_range) begin
          oob_hit <= 1'b1;
        end else if (mem_req.write) begin
          wr_en_q[bank_sel] <= 1'b1;
        end else begin
          rd_en_q[bank_sel] <= 1'b1;
        end
      end
    end
  end

  // Payload shared by all banks, only the enabled one looks at it
  always_ff @(posedge clk) begin
    if (issue) begin
      offset_q <= offset;
      wdata_q  <= mem_req.wdata;
    end
  end

  always_comb begin
    for (int b = 0; b < scratch_pkg::BANKS; b++) begin
      bank_cmd[b].read_en  = rd_en_q[b];
      bank_cmd[b].write_en = wr_en_q[b];
      bank_cmd[b].offset   = offset_q;
      bank_cmd[b].wdata    = wdata_q;
    end
  end

endmodule

// File: logic/response_collect.sv
`timescale 1ns/1ps

module response_collect (
  input  logic                                                 clk,
  input  logic                                                 reset,
  input  logic                                                 req,
  input  logic [scratch_pkg::BANKS-1:0][scratch_pkg::WORD_W-1:0] read_data,
  input  logic [scratch_pkg::BANKS-1:0]                        read_done,
  input  logic [scratch_pkg::BANKS-1:0]                        write_done,
  input  logic                                                 oob_hit,
  output logic                                                 ack,
  output scratch_pkg::mem_rsp_t                                mem_rsp
);

  logic                           finish;
  logic [scratch_pkg::WORD_W-1:0] sel_data;

  // Only one bank finishes per request, so an OR of the gated words works
  always_comb begin
    sel_data = '0;
    for (int b = 0; b < scratch_pkg::BANKS; b++) begin
      if (read_done[b]) begin
        sel_data = sel_data | read_data[b];
      end
    end
  end

  // Any bank done or the oob verdict ends the request
  assign finish = (|read_done) || (|write_done) || oob_hit;

  // Ack side of the four-phase handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (ack && !req) begin
      ack <= 1'b0;
    end else if (finish) begin
      ack <= 1'b1;
    end
  end

  // Response held from one ack rise to the next
  always_ff @(posedge clk) begin
    if (finish) begin
      mem_rsp.rdata <= sel_data;
      mem_rsp.oob   <= oob_hit;
    end
  end

endmodule

// File: logic/scratch_mem_top.sv
`timescale 1ns/1ps

module scratch_mem_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  scratch_pkg::mem_req_t mem_req,
  output logic                  ack,
  output scratch_pkg::mem_rsp_t mem_rsp
);

  scratch_pkg::bank_cmd_t [scratch_pkg::BANKS-1:0]        bank_cmd;
  logic [scratch_pkg::BANKS-1:0][scratch_pkg::WORD_W-1:0] read_data;
  logic [scratch_pkg::BANKS-1:0]                          read_done;
  logic [scratch_pkg::BANKS-1:0]                          write_done;
  logic                                                   oob_hit;

  // Request side, turns the req level into one bank command
  request_dispatch dispatch_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .mem_req  (mem_req),
    .ack      (ack),
    .bank_cmd (bank_cmd),
    .oob_hit  (oob_hit)
  );

  // Four interleaved banks
  for (genvar b = 0; b < scratch_pkg::BANKS; b++) begin : g_bank
    word_bank bank_i (
      .clk        (clk),
      .reset      (reset),
      .cmd        (bank_cmd[b]),
      .read_data  (read_data[b]),
      .read_done  (read_done[b]),
      .write_done (write_done[b])
    );
  end

  // Response side and ack
  response_collect collect_i (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .read_data  (read_data),
    .read_done  (read_done),
    .write_done (write_done),
    .oob_hit    (oob_hit),
    .ack        (ack),
    .mem_rsp    (mem_rsp)
  );

endmodule

// File: tb/scratch_mem_assert.sv
`timescale 1ns/1ps

module scratch_mem_assert (
  input logic                                            clk,
  input logic                                            reset,
  input logic                                            req,
  input logic                                            ack,
  input scratch_pkg::bank_cmd_t [scratch_pkg::BANKS-1:0] bank_cmd
);

  logic [scratch_pkg::BANKS-1:0] rd_en;
  logic [scratch_pkg::BANKS-1:0] wr_en;

  int ack_rise_fails = 0;
  int ack_hold_fails = 0;
  int rd_wr_fails    = 0;
  int multi_fails    = 0;
  int failures;

  assign failures = ack_rise_fails + ack_hold_fails + rd_wr_fails + multi_fails;

  // Gather enables across banks
  always_comb begin
    for (int b = 0; b < scratch_pkg::BANKS; b++) begin
      rd_en[b] = bank_cmd[b].read_en;
      wr_en[b] = bank_cmd[b].write_en;
    end
  end

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else begin
      $error("ack rose while req was low");
      ack_rise_fails++;
    end

  // Ack held until the host lets go of req
  ack_holds: assert property (@(posedge clk) disable iff (reset)
    ack && req |=> ack)
    else begin
      $error("ack dropped while req was still high");
      ack_hold_fails++;
    end

  no_read_write_together: assert property (@(posedge clk) disable iff (reset)
    (rd_en & wr_en) == '0)
    else begin
      $error("a bank got read and write enables in the same cycle");
      rd_wr_fails++;
    end

  one_bank_at_most: assert property (@(posedge clk) disable iff (reset)
    $onehot0(rd_en | wr_en))
    else begin
      $error("more than one bank enabled in one cycle");
      multi_fails++;
    end

endmodule

bind scratch_mem_top scratch_mem_assert assert_i (
  .clk      (clk),
  .reset    (reset),
  .req      (req),
  .ack      (ack),
  .bank_cmd (bank_cmd)
);

// File: tb/scratch_mem_tb.sv
`timescale 1ns/1ps

module scratch_mem_tb;

  // Transactions issued by the stimulus below
  localparam int N_TRANS     = 536;
  localparam int RESET_LEN   = 16;
  localparam int CYCLE_LIMIT = N_TRANS * 40 + RESET_LEN;

  logic                  clk;
  logic                  reset;
  logic                  req;
  scratch_pkg::mem_req_t mem_req;
  logic                  ack;
  scratch_pkg::mem_rsp_t mem_rsp;

  // Host view of the array, updated as writes are issued
  logic [31:0] shadow [scratch_pkg::ROWS][scratch_pkg::COLS];

  scratch_pkg::mem_req_t req_q [$];
  scratch_pkg::mem_rsp_t exp_q [$];
  scratch_pkg::mem_req_t cmp_req;
  scratch_pkg::mem_rsp_t cmp_exp;

  logic ack_prev = 1'b0;
  int   errors   = 0;
  int   checks   = 0;
  int   cycles   = 0;

  scratch_mem_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .mem_req (mem_req),
    .ack     (ack),
    .mem_rsp (mem_rsp)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Expected response from the shadow array
  function automatic scratch_pkg::mem_rsp_t expected_rsp(input scratch_pkg::mem_req_t r);
    scratch_pkg::mem_rsp_t rsp;
    rsp.oob   = 1'b0;
    rsp.rdata = '0;
    if (32'(r.row) >= scratch_pkg::ROWS || 32'(r.col) >= scratch_pkg::COLS) begin
      rsp.oob = 1'b1;
    end else if (!r.write) begin
      rsp.rdata = shadow[r.row][r.col];
    end
    return rsp;
  endfunction

  // One full four-phase transaction, req held for hold extra cycles after ack
  task automatic run_transaction(input logic write, input int row, input int col,
                                 input logic [31:0] wdata, input int hold);
    scratch_pkg::mem_req_t r;
    r.write = write;
    r.row   = scratch_pkg::ROW_W'(row);
    r.col   = scratch_pkg::COL_W'(col);
    r.wdata = wdata;
    req_q.push_back(r);
    exp_q.push_back(expected_rsp(r));
    if (write && row < scratch_pkg::ROWS && col < scratch_pkg::COLS) begin
      shadow[row][col] = wdata;
    end
    @(negedge clk);
    mem_req = r;
    req     = 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    repeat (hold) @(negedge clk);
    req = 1'b0;
    while (ack) @(negedge clk);
  endtask

  // Compare each response when ack rises
  always @(negedge clk) begin
    if (!reset && ack && !ack_prev) begin
      if (exp_q.size() == 0) begin
        $display("ack rose with no request outstanding");
        errors++;
      end else begin
        cmp_req = req_q.pop_front();
        cmp_exp = exp_q.pop_front();
        check_value("mem_rsp.oob", 32'(mem_rsp.oob), 32'(cmp_exp.oob));
        if (!cmp_req.write && !cmp_exp.oob) begin
          check_value("mem_rsp.rdata", mem_rsp.rdata, cmp_exp.rdata);
        end
      end
    end
    ack_prev = ack;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a transaction never completed", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    int r;
    int c;
    int i;
    int flat;
    int flat2;
    int hold_row [20];
    int hold_col [20];

    void'($urandom(32'h8c7f));
    clk     = 1'b0;
    reset   = 1'b1;
    req     = 1'b0;
    mem_req = '0;
    repeat (RESET_LEN) @(negedge clk);
    reset = 1'b0;

    // Fill every word, then read all back
    for (r = 0; r < scratch_pkg::ROWS; r++) begin
      for (c = 0; c < scratch_pkg::COLS; c++) begin
        run_transaction(1'b1, r, c, {8'h5a, 8'(r), 8'(c), 8'(r * scratch_pkg::COLS + c)}, 0);
      end
    end
    for (r = 0; r < scratch_pkg::ROWS; r++) begin
      for (c = 0; c < scratch_pkg::COLS; c++) begin
        run_transaction(1'b0, r, c, 32'h0, 0);
      end
    end

    // Random mix
    repeat (100) begin
      r = int'($urandom_range(scratch_pkg::ROWS - 1));
      c = int'($urandom_range(scratch_pkg::COLS - 1));
      run_transaction(1'($urandom_range(1)), r, c, $urandom, 0);
    end

    // Write then read in the same bank, step of 4 keeps the bank select
    for (i = 0; i < 50; i++) begin
      flat  = int'($urandom_range(95));
      flat2 = (flat + 4 * int'($urandom_range(23))) % 96;
      run_transaction(1'b1, flat / scratch_pkg::COLS, flat % scratch_pkg::COLS, $urandom, 0);
      run_transaction(1'b0, flat2 / scratch_pkg::COLS, flat2 % scratch_pkg::COLS, 32'h0, 0);
    end

    // Rows past the array must not touch any bank
    for (r = scratch_pkg::ROWS; r < 16; r++) begin
      for (c = 0; c < scratch_pkg::COLS; c++) begin
        run_transaction(1'b1, r, c, $urandom, 0);
      end
    end
    repeat (8) begin
      run_transaction(1'b0, int'($urandom_range(15, 12)), int'($urandom_range(7)), 32'h0, 0);
    end
    // Locations that sit 96 words lower still hold their data
    for (r = scratch_pkg::ROWS; r < 16; r++) begin
      for (c = 0; c < scratch_pkg::COLS; c++) begin
        run_transaction(1'b0, r - scratch_pkg::ROWS, c, 32'h0, 0);
      end
    end

    // Write followed by read of the same word
    repeat (16) begin
      r = int'($urandom_range(scratch_pkg::ROWS - 1));
      c = int'($urandom_range(scratch_pkg::COLS - 1));
      run_transaction(1'b1, r, c, $urandom, 0);
      run_transaction(1'b0, r, c, 32'h0, 0);
    end

    // Host stalls with req high after ack
    for (i = 0; i < 20; i++) begin
      hold_row[i] = int'($urandom_range(scratch_pkg::ROWS - 1));
      hold_col[i] = int'($urandom_range(scratch_pkg::COLS - 1));
      run_transaction(1'b1, hold_row[i], hold_col[i], $urandom, int'($urandom_range(8, 1)));
    end
    for (i = 0; i < 20; i++) begin
      run_transaction(1'b0, hold_row[i], hold_col[i], 32'h0, int'($urandom_range(8, 1)));
    end

    repeat (4) @(negedge clk);
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, dut_i.assert_i.failures);
    if (errors == 0 && dut_i.assert_i.failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: compile.f
logic/scratch_pkg.sv
logic/word_bank.sv
logic/request_dispatch.sv
logic/response_collect.sv
logic/scratch_mem_top.sv
tb/scratch_mem_assert.sv
tb/scratch_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= scratch_mem_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
